//--- hw/tlx_cmd_pkg.sv
// field types, credit types, arbiter turn and widths for the TLX command converter
`default_nettype none

package tlx_cmd_pkg;

  // ------------------------------
  // command fields
  // ------------------------------
  typedef logic [7:0]  opcode_t;
  typedef logic [15:0] afutag_t;
  typedef logic [67:0] ea_t;
  typedef logic [1:0]  dl_t;
  typedef logic [2:0]  pl_t;
  typedef logic [11:0] actag_t;
  typedef logic [19:0] pasid_t;
  typedef logic [15:0] bdf_t;

  // one write beat, narrowed from the 512-bit TLX data bus
  localparam int CDATA_W = 64;
  typedef logic [CDATA_W-1:0] cdata_t;

  // ------------------------------
  // credits
  // ------------------------------
  localparam int CMD_CREDIT_W  = 4;
  localparam int DATA_CREDIT_W = 6;
  typedef logic [CMD_CREDIT_W-1:0]  cmd_credit_t;
  typedef logic [DATA_CREDIT_W-1:0] data_credit_t;

  // which queue has priority on the next tie
  typedef enum logic
  {
    TURN_READ  = 1'b0,
    TURN_WRITE = 1'b1
  } turn_t;

  // packed record {pasid, actag, pl, dl, afutag, ea, opcode}, 129 bits
  localparam int CMD_INFO_W = $bits(pasid_t) + $bits(actag_t) + $bits(pl_t) +
                              $bits(dl_t) + $bits(afutag_t) + $bits(ea_t) +
                              $bits(opcode_t);

  localparam int QUEUE_DEPTH = 16;

endpackage

`default_nettype wire

//--- hw/cmd_queue.sv
// first-word-fall-through command queue with half-full ready and overflow pulse
`timescale 1ns/1ps
`default_nettype none

module cmd_queue import tlx_cmd_pkg::*; #(
  parameter int WIDTH = CMD_INFO_W,
  parameter int DEPTH = QUEUE_DEPTH
) (
  input  logic             clock_tlx,
  input  logic             rst_n,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  input  logic             pop,
  output logic [WIDTH-1:0] head_data,
  output logic             not_empty,
  output logic             ready,
  output logic             overflow
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);
  localparam logic [AW-1:0] LAST_PTR = AW'(DEPTH - 1);
  localparam logic [CW-1:0] FULL_CNT = CW'(DEPTH);
  localparam logic [CW-1:0] HALF_CNT = CW'(DEPTH / 2);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    fill;
  logic             full;
  logic             do_push;
  logic             do_pop;

  // pointer advance with wrap, depth need not be a power of two
  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
  endfunction

  assign full      = (fill == FULL_CNT);
  assign not_empty = (fill != '0);
  // source must stop once half the entries are taken
  assign ready     = (fill < HALF_CNT);
  assign do_push   = push && !full;
  assign do_pop    = pop && not_empty;

  // head shown straight from the array
  assign head_data = mem[rd_ptr];

  always_ff @(posedge clock_tlx)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clock_tlx or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill     <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= next_ptr(wr_ptr);
      if (do_pop)
        rd_ptr <= next_ptr(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      // dropped push, one cycle
      overflow <= push && full;
    end
  end

endmodule

`default_nettype wire

//--- hw/cmd_arbiter.sv
// credit-gated alternating arbiter between write and read queues, registered TLX command
`timescale 1ns/1ps
`default_nettype none

module cmd_arbiter import tlx_cmd_pkg::*; (
  input  logic                  clock_tlx,
  input  logic                  rst_n,
  input  logic                  wr_not_empty,
  input  logic [CMD_INFO_W-1:0] wr_head,
  input  cdata_t                wr_head_data,
  input  logic                  rd_not_empty,
  input  logic [CMD_INFO_W-1:0] rd_head,
  input  logic                  cmd_credit_ok,
  input  logic                  data_credit_ok,
  output logic                  wr_pop,
  output logic                  rd_pop,
  output logic                  cmd_consume,
  output logic                  data_consume,
  output logic                  cmd_valid,
  output logic [CMD_INFO_W-1:0] cmd_record,
  output logic                  cdata_valid,
  output cdata_t                cdata
);

  turn_t turn;
  logic  wr_ok;
  logic  rd_ok;
  logic  grant;

  // ------------------------------
  // selection
  // ------------------------------

  // a write needs both a command and a data credit
  assign wr_ok = wr_not_empty && cmd_credit_ok && data_credit_ok;
  assign rd_ok = rd_not_empty && cmd_credit_ok;

  // turn only matters when both sides can go
  assign wr_pop = wr_ok && (!rd_ok || (turn == TURN_WRITE));
  assign rd_pop = rd_ok && !wr_pop;
  assign grant  = wr_pop || rd_pop;

  assign cmd_consume  = grant;
  assign data_consume = wr_pop;

  always_ff @(posedge clock_tlx or negedge rst_n)
  begin
    if (!rst_n)
      turn <= TURN_READ;
    else if (grant)
      turn <= wr_pop ? TURN_READ : TURN_WRITE;
  end

  // ------------------------------
  // TLX output stage
  // ------------------------------

  always_ff @(posedge clock_tlx or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cmd_valid   <= 1'b0;
      cdata_valid <= 1'b0;
    end
    else
    begin
      cmd_valid   <= grant;
      cdata_valid <= wr_pop;
    end
  end

  // payload only follows a grant, otherwise held
  always_ff @(posedge clock_tlx)
  begin
    if (grant)
      cmd_record <= wr_pop ? wr_head : rd_head;
    if (wr_pop)
      cdata <= wr_head_data;
  end

endmodule

`default_nettype wire

//--- hw/credit_counter.sv
// TLX credit counter with initial load, return and consume tracking, overflow flag
`timescale 1ns/1ps
`default_nettype none

module credit_counter #(
  parameter int WIDTH = 4
) (
  input  logic             clock_tlx,
  input  logic             rst_n,
  input  logic [WIDTH-1:0] initial_credit,
  input  logic             credit_return,
  input  logic             consume,
  output logic             available,
  output logic             overflow
);

  localparam logic [WIDTH-1:0] MAX_COUNT = '1;

  logic [WIDTH-1:0] count;
  logic             loaded;
  logic             at_max;

  assign at_max    = (count == MAX_COUNT);
  // one credit is enough for one command or one data beat
  assign available = (count != '0);

  always_ff @(posedge clock_tlx or negedge rst_n)
  begin
    if (!rst_n)
    begin
      count    <= '0;
      loaded   <= 1'b0;
      overflow <= 1'b0;
    end
    else if (!loaded)
    begin
      // first clock after reset release
      count    <= initial_credit;
      loaded   <= 1'b1;
      overflow <= 1'b0;
    end
    else
    begin
      overflow <= credit_return && !consume && at_max;
      case ({credit_return, consume})
        2'b10:
        begin
          // saturate on a surplus return
          if (!at_max)
            count <= count + 1'b1;
        end
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/fault_isolation.sv
// sticky fault-isolation bits for queue overflow and credit overflow
`timescale 1ns/1ps
`default_nettype none

module fault_isolation (
  input  logic       clock_tlx,
  input  logic       rst_n,
  input  logic       wr_queue_overflow,
  input  logic       rd_queue_overflow,
  input  logic       cmd_credit_overflow,
  input  logic       data_credit_overflow,
  output logic [1:0] fir_fifo_overflow,
  output logic [1:0] fir_tlx_command_credit
);

  // fir_fifo_overflow: bit 1 write queue, bit 0 read queue
  // fir_tlx_command_credit: bit 1 command credit, bit 0 data credit
  always_ff @(posedge clock_tlx or negedge rst_n)
  begin
    if (!rst_n)
    begin
      fir_fifo_overflow      <= 2'b00;
      fir_tlx_command_credit <= 2'b00;
    end
    else
    begin
      if (wr_queue_overflow)
        fir_fifo_overflow[1] <= 1'b1;
      if (rd_queue_overflow)
        fir_fifo_overflow[0] <= 1'b1;
      if (cmd_credit_overflow)
        fir_tlx_command_credit[1] <= 1'b1;
      if (data_credit_overflow)
        fir_tlx_command_credit[0] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/tlx_cmd_converter.sv
// TLX command converter top level: queues, arbiter, credit counters and fault register
`timescale 1ns/1ps
`default_nettype none

module tlx_cmd_converter import tlx_cmd_pkg::*; #(
  parameter int QUEUE_DEPTH = tlx_cmd_pkg::QUEUE_DEPTH
) (
  input  logic         clock_tlx,
  input  logic         rst_n,
  input  logic [7:0]   cfg_bdf_bus,
  input  logic [4:0]   cfg_bdf_device,
  input  logic [2:0]   cfg_bdf_function,
  // write channel
  input  logic         wr_cmd_valid,
  input  opcode_t      wr_cmd_opcode,
  input  ea_t          wr_cmd_ea_or_obj,
  input  afutag_t      wr_cmd_afutag,
  input  dl_t          wr_cmd_dl,
  input  pl_t          wr_cmd_pl,
  input  actag_t       wr_cmd_actag,
  input  pasid_t       wr_cmd_pasid,
  input  cdata_t       wr_cdata,
  output logic         wr_cmd_ready,
  // read channel
  input  logic         rd_cmd_valid,
  input  opcode_t      rd_cmd_opcode,
  input  ea_t          rd_cmd_ea_or_obj,
  input  afutag_t      rd_cmd_afutag,
  input  dl_t          rd_cmd_dl,
  input  pl_t          rd_cmd_pl,
  input  actag_t       rd_cmd_actag,
  input  pasid_t       rd_cmd_pasid,
  output logic         rd_cmd_ready,
  // credits from TLX
  input  logic         tlx_cmd_credit,
  input  logic         tlx_data_credit,
  input  cmd_credit_t  tlx_cmd_initial_credit,
  input  data_credit_t tlx_data_initial_credit,
  // TLX command and data
  output logic         afu_tlx_cmd_valid,
  output opcode_t      afu_tlx_cmd_opcode,
  output ea_t          afu_tlx_cmd_ea_or_obj,
  output afutag_t      afu_tlx_cmd_afutag,
  output dl_t          afu_tlx_cmd_dl,
  output pl_t          afu_tlx_cmd_pl,
  output actag_t       afu_tlx_cmd_actag,
  output pasid_t       afu_tlx_cmd_pasid,
  output bdf_t         afu_tlx_cmd_bdf,
  output logic         afu_tlx_cdata_valid,
  output cdata_t       afu_tlx_cdata_bus,
  // fault isolation
  output logic [1:0]   fir_fifo_overflow,
  output logic [1:0]   fir_tlx_command_credit
);

  localparam int WR_WIDTH = CMD_INFO_W + $bits(cdata_t);

  logic [WR_WIDTH-1:0]   wr_push_data;
  logic [WR_WIDTH-1:0]   wr_queue_head;
  logic [CMD_INFO_W-1:0] wr_head;
  cdata_t                wr_head_data;
  logic [CMD_INFO_W-1:0] rd_push_data;
  logic [CMD_INFO_W-1:0] rd_head;
  logic [CMD_INFO_W-1:0] tlx_record;
  logic                  wr_not_empty;
  logic                  rd_not_empty;
  logic                  wr_pop;
  logic                  rd_pop;
  logic                  wr_overflow;
  logic                  rd_overflow;
  logic                  cmd_consume;
  logic                  data_consume;
  logic                  cmd_available;
  logic                  data_available;
  logic                  cmd_credit_overflow;
  logic                  data_credit_overflow;

  // ------------------------------
  // record packing
  // ------------------------------
  assign wr_push_data = {wr_cdata, wr_cmd_pasid, wr_cmd_actag, wr_cmd_pl, wr_cmd_dl,
                         wr_cmd_afutag, wr_cmd_ea_or_obj, wr_cmd_opcode};
  assign rd_push_data = {rd_cmd_pasid, rd_cmd_actag, rd_cmd_pl, rd_cmd_dl,
                         rd_cmd_afutag, rd_cmd_ea_or_obj, rd_cmd_opcode};
  assign {wr_head_data, wr_head} = wr_queue_head;

  assign {afu_tlx_cmd_pasid, afu_tlx_cmd_actag, afu_tlx_cmd_pl, afu_tlx_cmd_dl,
          afu_tlx_cmd_afutag, afu_tlx_cmd_ea_or_obj, afu_tlx_cmd_opcode} = tlx_record;
  assign afu_tlx_cmd_bdf = {cfg_bdf_bus, cfg_bdf_device, cfg_bdf_function};

  // ------------------------------
  // queues
  // ------------------------------
  cmd_queue #(.WIDTH(WR_WIDTH), .DEPTH(QUEUE_DEPTH)) write_queue (
    .clock_tlx (clock_tlx),
    .rst_n     (rst_n),
    .push      (wr_cmd_valid),
    .push_data (wr_push_data),
    .pop       (wr_pop),
    .head_data (wr_queue_head),
    .not_empty (wr_not_empty),
    .ready     (wr_cmd_ready),
    .overflow  (wr_overflow)
  );

  cmd_queue #(.WIDTH(CMD_INFO_W), .DEPTH(QUEUE_DEPTH)) read_queue (
    .clock_tlx (clock_tlx),
    .rst_n     (rst_n),
    .push      (rd_cmd_valid),
    .push_data (rd_push_data),
    .pop       (rd_pop),
    .head_data (rd_head),
    .not_empty (rd_not_empty),
    .ready     (rd_cmd_ready),
    .overflow  (rd_overflow)
  );

  cmd_arbiter arbiter (
    .clock_tlx      (clock_tlx),
    .rst_n          (rst_n),
    .wr_not_empty   (wr_not_empty),
    .wr_head        (wr_head),
    .wr_head_data   (wr_head_data),
    .rd_not_empty   (rd_not_empty),
    .rd_head        (rd_head),
    .cmd_credit_ok  (cmd_available),
    .data_credit_ok (data_available),
    .wr_pop         (wr_pop),
    .rd_pop         (rd_pop),
    .cmd_consume    (cmd_consume),
    .data_consume   (data_consume),
    .cmd_valid      (afu_tlx_cmd_valid),
    .cmd_record     (tlx_record),
    .cdata_valid    (afu_tlx_cdata_valid),
    .cdata          (afu_tlx_cdata_bus)
  );

  // ------------------------------
  // credits and faults
  // ------------------------------
  credit_counter #(.WIDTH($bits(cmd_credit_t))) cmd_credit (
    .clock_tlx      (clock_tlx),
    .rst_n          (rst_n),
    .initial_credit (tlx_cmd_initial_credit),
    .credit_return  (tlx_cmd_credit),
    .consume        (cmd_consume),
    .available      (cmd_available),
    .overflow       (cmd_credit_overflow)
  );

  credit_counter #(.WIDTH($bits(data_credit_t))) data_credit (
    .clock_tlx      (clock_tlx),
    .rst_n          (rst_n),
    .initial_credit (tlx_data_initial_credit),
    .credit_return  (tlx_data_credit),
    .consume        (data_consume),
    .available      (data_available),
    .overflow       (data_credit_overflow)
  );

  fault_isolation fir (
    .clock_tlx              (clock_tlx),
    .rst_n                  (rst_n),
    .wr_queue_overflow      (wr_overflow),
    .rd_queue_overflow      (rd_overflow),
    .cmd_credit_overflow    (cmd_credit_overflow),
    .data_credit_overflow   (data_credit_overflow),
    .fir_fifo_overflow      (fir_fifo_overflow),
    .fir_tlx_command_credit (fir_tlx_command_credit)
  );

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
// testbench clock and reset generator with restart request
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 3
) (
  input  logic restart,
  output logic clock_tlx,
  output logic rst_n
);

  initial
  begin
    clock_tlx = 1'b0;
    forever
      #(PERIOD / 2) clock_tlx = ~clock_tlx;
  end

  // reset edges land on the falling clock edge
  initial
  begin
    rst_n = 1'b0;
    forever
    begin
      repeat (RESET_CYCLES) @(posedge clock_tlx);
      @(negedge clock_tlx);
      rst_n = 1'b1;
      @(posedge restart);
      @(negedge clock_tlx);
      rst_n = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- tests/tlx_cmd_converter_assert.sv
// concurrent assertions on the command arbiter, bound into cmd_arbiter
`timescale 1ns/1ps
`default_nettype none

module tlx_cmd_converter_assert (
  input logic clock_tlx,
  input logic rst_n,
  input logic wr_pop,
  input logic rd_pop,
  input logic cmd_valid,
  input logic cdata_valid
);

  one_grant: assert property (@(posedge clock_tlx) disable iff (!rst_n)
    !(wr_pop && rd_pop))
    else $error("write and read queue popped in the same cycle");

  // output only one cycle after a grant
  valid_after_grant: assert property (@(posedge clock_tlx) disable iff (!rst_n)
    cmd_valid |-> $past(wr_pop || rd_pop))
    else $error("cmd_valid without a grant in the previous cycle");

  data_with_write: assert property (@(posedge clock_tlx) disable iff (!rst_n)
    $past(wr_pop) |-> (cdata_valid == cmd_valid))
    else $error("cdata_valid differs from cmd_valid after a write grant");

endmodule

bind cmd_arbiter tlx_cmd_converter_assert arbiter_checks (
  .clock_tlx   (clock_tlx),
  .rst_n       (rst_n),
  .wr_pop      (wr_pop),
  .rd_pop      (rd_pop),
  .cmd_valid   (cmd_valid),
  .cdata_valid (cdata_valid)
);

`default_nettype wire

//--- tests/tlx_cmd_converter_tb.sv
// testbench with stimulus file reader, cycle reference model, compare tasks and report
`timescale 1ns/1ps
`default_nettype none

module tlx_cmd_converter_tb import tlx_cmd_pkg::*; ();

  localparam int DEPTH   = 16;
  localparam int TIMEOUT = 200;
  localparam int CMD_MAX  = (1 << $bits(cmd_credit_t)) - 1;
  localparam int DATA_MAX = (1 << $bits(data_credit_t)) - 1;
  localparam logic [7:0] BDF_BUS = 8'h3a;
  localparam logic [4:0] BDF_DEV = 5'h11;
  localparam logic [2:0] BDF_FN  = 3'h5;

  typedef struct packed {
    opcode_t opcode;
    ea_t     ea;
    afutag_t afutag;
    dl_t     dl;
    pl_t     pl;
    actag_t  actag;
    pasid_t  pasid;
  } cmd_rec_t;

  logic clock_tlx;
  logic rst_n;
  logic restart;
  logic wr_cmd_valid, rd_cmd_valid, wr_cmd_ready, rd_cmd_ready;
  opcode_t wr_cmd_opcode, rd_cmd_opcode, afu_tlx_cmd_opcode;
  ea_t wr_cmd_ea_or_obj, rd_cmd_ea_or_obj, afu_tlx_cmd_ea_or_obj;
  afutag_t wr_cmd_afutag, rd_cmd_afutag, afu_tlx_cmd_afutag;
  dl_t wr_cmd_dl, rd_cmd_dl, afu_tlx_cmd_dl;
  pl_t wr_cmd_pl, rd_cmd_pl, afu_tlx_cmd_pl;
  actag_t wr_cmd_actag, rd_cmd_actag, afu_tlx_cmd_actag;
  pasid_t wr_cmd_pasid, rd_cmd_pasid, afu_tlx_cmd_pasid;
  cdata_t wr_cdata, afu_tlx_cdata_bus;
  logic tlx_cmd_credit, tlx_data_credit, afu_tlx_cmd_valid, afu_tlx_cdata_valid;
  cmd_credit_t tlx_cmd_initial_credit;
  data_credit_t tlx_data_initial_credit;
  bdf_t afu_tlx_cmd_bdf;
  logic [1:0] fir_fifo_overflow, fir_tlx_command_credit;

  int seed;
  int error_count;

  // ------------------------------
  // reference model state
  // ------------------------------
  cmd_rec_t wr_model_q[$];
  cdata_t wr_data_q[$];
  cmd_rec_t rd_model_q[$];
  turn_t model_turn;
  int model_cmd_credit, model_data_credit;
  logic model_loaded, exp_valid, exp_write;
  cmd_rec_t exp_rec;
  cdata_t exp_data;
  logic [1:0] model_fir_fifo, model_fir_credit, pend_fifo, pend_credit;

  tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(3)) clock_gen (
    .restart   (restart),
    .clock_tlx (clock_tlx),
    .rst_n     (rst_n)
  );

  tlx_cmd_converter #(.QUEUE_DEPTH(DEPTH)) dut (.*, .cfg_bdf_bus(BDF_BUS),
    .cfg_bdf_device(BDF_DEV), .cfg_bdf_function(BDF_FN));

  task automatic finish_run();
    $display("%0d errors", error_count);
    if (error_count == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("Error: timed out waiting for %s at %0t", what, $time);
    error_count++;
    finish_run();
  endtask

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp)
    begin
      $display("Fail %0t: %s is %b, expected %b", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_fir(input logic [1:0] got, input logic [1:0] exp, input string name);
    if (got !== exp)
    begin
      $display("Fail %0t: %s is %b, expected %b", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_cmd(input cmd_rec_t exp);
    cmd_rec_t got;
    got = '{afu_tlx_cmd_opcode, afu_tlx_cmd_ea_or_obj, afu_tlx_cmd_afutag, afu_tlx_cmd_dl,
            afu_tlx_cmd_pl, afu_tlx_cmd_actag, afu_tlx_cmd_pasid};
    if (got !== exp)
    begin
      $display("Fail %0t: command %h, expected %h", $time, got, exp);
      error_count++;
    end
    if (afu_tlx_cmd_bdf !== bdf_t'({BDF_BUS, BDF_DEV, BDF_FN}))
    begin
      $display("Fail %0t: bdf %h is wrong", $time, afu_tlx_cmd_bdf);
      error_count++;
    end
  endtask

  task automatic check_cdata(input cdata_t got, input cdata_t exp);
    if (got !== exp)
    begin
      $display("Fail %0t: write data %h, expected %h", $time, got, exp);
      error_count++;
    end
  endtask

  // outputs are compared before the model steps over this edge
  always @(posedge clock_tlx)
  begin : reference_model
    logic wr_ok, rd_ok, grant_wr, grant_rd, wr_full, rd_full;
    if (!rst_n)
    begin
      wr_model_q.delete();
      wr_data_q.delete();
      rd_model_q.delete();
      model_turn = TURN_READ;
      model_cmd_credit = 0;
      model_data_credit = 0;
      {model_loaded, exp_valid, exp_write} = 3'b000;
      {model_fir_fifo, model_fir_credit, pend_fifo, pend_credit} = 8'h00;
    end
    else
    begin
      check_flag(afu_tlx_cmd_valid, exp_valid, "afu_tlx_cmd_valid");
      check_flag(afu_tlx_cdata_valid, exp_valid && exp_write, "afu_tlx_cdata_valid");
      if (exp_valid && afu_tlx_cmd_valid)
      begin
        check_cmd(exp_rec);
        if (exp_write)
          check_cdata(afu_tlx_cdata_bus, exp_data);
      end
      check_fir(fir_fifo_overflow, model_fir_fifo, "fir_fifo_overflow");
      check_fir(fir_tlx_command_credit, model_fir_credit, "fir_tlx_command_credit");
      check_flag(wr_cmd_ready, wr_model_q.size() < DEPTH / 2, "wr_cmd_ready");
      check_flag(rd_cmd_ready, rd_model_q.size() < DEPTH / 2, "rd_cmd_ready");

      wr_full = (wr_model_q.size() == DEPTH);
      rd_full = (rd_model_q.size() == DEPTH);
      wr_ok = (wr_model_q.size() > 0) && (model_cmd_credit > 0) && (model_data_credit > 0);
      rd_ok = (rd_model_q.size() > 0) && (model_cmd_credit > 0);
      grant_wr = wr_ok && (!rd_ok || model_turn == TURN_WRITE);
      grant_rd = rd_ok && !grant_wr;
      exp_valid = grant_wr || grant_rd;
      exp_write = grant_wr;
      if (grant_wr)
      begin
        exp_rec = wr_model_q.pop_front();
        exp_data = wr_data_q.pop_front();
        model_turn = TURN_READ;
      end
      else if (grant_rd)
      begin
        exp_rec = rd_model_q.pop_front();
        model_turn = TURN_WRITE;
      end

      // fault bits follow their pulse by one cycle
      model_fir_fifo = model_fir_fifo | pend_fifo;
      model_fir_credit = model_fir_credit | pend_credit;
      pend_fifo = 2'b00;
      pend_credit = 2'b00;

      if (!model_loaded)
      begin
        model_cmd_credit = int'(tlx_cmd_initial_credit);
        model_data_credit = int'(tlx_data_initial_credit);
        model_loaded = 1'b1;
      end
      else
      begin
        if (tlx_cmd_credit && !exp_valid)
        begin
          if (model_cmd_credit == CMD_MAX)
            pend_credit[1] = 1'b1;
          else
            model_cmd_credit++;
        end
        else if (!tlx_cmd_credit && exp_valid)
          model_cmd_credit--;
        if (tlx_data_credit && !grant_wr)
        begin
          if (model_data_credit == DATA_MAX)
            pend_credit[0] = 1'b1;
          else
            model_data_credit++;
        end
        else if (!tlx_data_credit && grant_wr)
          model_data_credit--;
      end

      if (wr_cmd_valid && wr_full)
        pend_fifo[1] = 1'b1;
      else if (wr_cmd_valid)
      begin
        wr_model_q.push_back('{wr_cmd_opcode, wr_cmd_ea_or_obj, wr_cmd_afutag, wr_cmd_dl,
                               wr_cmd_pl, wr_cmd_actag, wr_cmd_pasid});
        wr_data_q.push_back(wr_cdata);
      end
      if (rd_cmd_valid && rd_full)
        pend_fifo[0] = 1'b1;
      else if (rd_cmd_valid)
        rd_model_q.push_back('{rd_cmd_opcode, rd_cmd_ea_or_obj, rd_cmd_afutag, rd_cmd_dl,
                               rd_cmd_pl, rd_cmd_actag, rd_cmd_pasid});
    end
  end

  // ------------------------------
  // stimulus tasks
  // ------------------------------

  // every strobe falls back to low unless the caller drives it again
  task automatic drive_cycle();
    @(posedge clock_tlx);
    wr_cmd_valid <= 1'b0;
    rd_cmd_valid <= 1'b0;
    tlx_cmd_credit <= 1'b0;
    tlx_data_credit <= 1'b0;
  endtask

  task automatic push_write(input opcode_t op, input logic honor_ready);
    int n;
    int r0, r1, r2, r3, r4, r5;
    n = 0;
    @(negedge clock_tlx);
    while (honor_ready && !wr_cmd_ready)
    begin
      drive_cycle();
      @(negedge clock_tlx);
      n++;
      if (n > TIMEOUT)
        report_timeout("wr_cmd_ready");
    end
    r0 = $random(seed);
    r1 = $random(seed);
    r2 = $random(seed);
    r3 = $random(seed);
    r4 = $random(seed);
    r5 = $random(seed);
    drive_cycle();
    wr_cmd_valid <= 1'b1;
    wr_cmd_opcode <= op;
    wr_cmd_ea_or_obj <= {r2[3:0], r1, r0};
    wr_cmd_afutag <= r3[15:0];
    wr_cmd_dl <= r3[17:16];
    wr_cmd_pl <= r3[20:18];
    wr_cmd_actag <= r3[31:20];
    wr_cmd_pasid <= r4[19:0];
    wr_cdata <= {r5, r4};
  endtask

  task automatic push_read(input opcode_t op);
    int n;
    int r0, r1, r2, r3, r4;
    n = 0;
    @(negedge clock_tlx);
    while (!rd_cmd_ready)
    begin
      drive_cycle();
      @(negedge clock_tlx);
      n++;
      if (n > TIMEOUT)
        report_timeout("rd_cmd_ready");
    end
    r0 = $random(seed);
    r1 = $random(seed);
    r2 = $random(seed);
    r3 = $random(seed);
    r4 = $random(seed);
    drive_cycle();
    rd_cmd_valid <= 1'b1;
    rd_cmd_opcode <= op;
    rd_cmd_ea_or_obj <= {r2[3:0], r1, r0};
    rd_cmd_afutag <= r3[15:0];
    rd_cmd_dl <= r3[17:16];
    rd_cmd_pl <= r3[20:18];
    rd_cmd_actag <= r3[31:20];
    rd_cmd_pasid <= r4[19:0];
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    drive_cycle();
    @(negedge clock_tlx);
    while (wr_model_q.size() != 0 || rd_model_q.size() != 0 || exp_valid)
    begin
      drive_cycle();
      @(negedge clock_tlx);
      n++;
      if (n > TIMEOUT)
        report_timeout("queues to drain");
    end
  endtask

  // return both credits every cycle so that every queued command comes out
  task automatic flush_queues();
    int n;
    n = 0;
    while (wr_model_q.size() != 0 || rd_model_q.size() != 0)
    begin
      drive_cycle();
      tlx_cmd_credit <= 1'b1;
      tlx_data_credit <= 1'b1;
      @(negedge clock_tlx);
      n++;
      if (n > TIMEOUT)
        report_timeout("queues to flush");
    end
    wait_drained();
  endtask

  task automatic apply_reset(input cmd_credit_t cmd_init, input data_credit_t data_init);
    int n;
    n = 0;
    drive_cycle();
    tlx_cmd_initial_credit <= cmd_init;
    tlx_data_initial_credit <= data_init;
    if (rst_n)
    begin
      restart <= 1'b1;
      while (rst_n)
      begin
        @(posedge clock_tlx);
        n++;
        if (n > TIMEOUT)
          report_timeout("reset assertion");
      end
      restart <= 1'b0;
    end
    n = 0;
    while (!rst_n)
    begin
      @(posedge clock_tlx);
      n++;
      if (n > TIMEOUT)
        report_timeout("reset release");
    end
  endtask

  initial
  begin : stimulus
    int fd, code;
    string line;
    logic [7:0] act;
    logic [31:0] a, b;
    seed = 59;
    error_count = 0;
    restart = 1'b0;
    {wr_cmd_valid, rd_cmd_valid, tlx_cmd_credit, tlx_data_credit} = 4'b0000;
    {wr_cmd_opcode, wr_cmd_ea_or_obj, wr_cmd_afutag, wr_cmd_dl} = '0;
    {wr_cmd_pl, wr_cmd_actag, wr_cmd_pasid, wr_cdata} = '0;
    {rd_cmd_opcode, rd_cmd_ea_or_obj, rd_cmd_afutag, rd_cmd_dl} = '0;
    {rd_cmd_pl, rd_cmd_actag, rd_cmd_pasid} = '0;
    tlx_cmd_initial_credit = '0;
    tlx_data_initial_credit = '0;
    fd = $fopen("tests/tlx_cmd_stim.txt", "r");
    if (fd == 0)
    begin
      $display("Error: cannot open the stimulus file");
      error_count++;
    end
    while (fd != 0 && !$feof(fd))
    begin
      code = $fgets(line, fd);
      a = 0;
      b = 0;
      if (code > 1 && line.getc(0) != "#")
      begin
        code = $sscanf(line, "%c %h %h", act, a, b);
        case (act)
          "R": apply_reset(a[3:0], b[5:0]);
          "W": repeat (b) push_write(a[7:0], 1'b1);
          "O": repeat (b) push_write(a[7:0], 1'b0);
          "Q": repeat (b) push_read(a[7:0]);
          "C":
            repeat (a)
            begin
              drive_cycle();
              tlx_cmd_credit <= 1'b1;
            end
          "E":
            repeat (a)
            begin
              drive_cycle();
              tlx_data_credit <= 1'b1;
            end
          "I": repeat (a) drive_cycle();
          "D": wait_drained();
          "X":
          begin
            drive_cycle();
            @(negedge clock_tlx);
            check_fir(fir_fifo_overflow, a[1:0], "fir_fifo_overflow");
            check_fir(fir_tlx_command_credit, b[1:0], "fir_tlx_command_credit");
          end
          default:
          begin
            $display("Error: unknown stimulus line: %s", line);
            error_count++;
          end
        endcase
      end
    end
    // commands still queued must come out in order, a dropped push never does
    flush_queues();
    repeat (2) drive_cycle();
    finish_run();
  end

endmodule

`default_nettype wire

//--- tests/tlx_cmd_stim.txt
# action arg1 arg2 (hex): R cmd_init data_init, W/O opcode count, Q opcode count,
# C count, E count, I count, D drain, X expected fir_fifo_overflow fir_tlx_command_credit
R 0 0
X 0 0
W 20 3
Q 10 5
I 4
E 3
C 8
D
X 0 0
R 3 0
W 20 2
Q 10 4
I 8
C 6
E 2
D
R f 3f
W 20 6
Q 10 6
D
R 0 0
O 20 11
I 3
X 2 0
C 10
I 3
X 2 2
I 2
X 2 2

//--- filelist.f
hw/tlx_cmd_pkg.sv
hw/cmd_queue.sv
hw/cmd_arbiter.sv
hw/credit_counter.sv
hw/fault_isolation.sv
hw/tlx_cmd_converter.sv
tests/tb_clock_gen.sv
tests/tlx_cmd_converter_assert.sv
tests/tlx_cmd_converter_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tlx_cmd_converter_tb -f filelist.f -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "^Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
